// ==== Makefile ====
TOP = tb_rv_fetch

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== rv_decode_comp.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode_comp
    import rv_pkg::*;
(
    input   wire[31:0]      i_instruction,
    output  wire[31:0]      o_instruction,
    output  wire            o_compressed,
    output  wire            o_illegal_instruction
);

    logic [31:0]    instruction;
    logic           compressed;
    logic           illegal_instruction;
    logic [15:0]    ci;

    assign ci = i_instruction[15:0];

    always_comb
    begin
        instruction = i_instruction;
        compressed = 1'b1;
        illegal_instruction = 1'b0;
        case (rv_quadrant_e'(ci[1:0]))
        RV_Q0:
        begin
            case (ci[15:14])
            2'b00:
                // c.addi4spn -> addi rd', x2, nzuimm
                instruction = { 2'b00, ci[10:7], ci[12:11], ci[5], ci[6], 2'b00, 5'h02,
                                3'b000, 2'b01, ci[4:2], RV_OPC_OP_IMM, 2'b11 };
            2'b01:
                // c.lw -> lw rd', uimm(rs1')
                instruction = { 5'b0, ci[5], ci[12:10], ci[6], 2'b00, 2'b01, ci[9:7],
                                3'b010, 2'b01, ci[4:2], RV_OPC_LOAD, 2'b11 };
            2'b11:
                // c.sw -> sw rs2', uimm(rs1')
                instruction = { 5'b0, ci[5], ci[12], 2'b01, ci[4:2], 2'b01, ci[9:7],
                                3'b010, ci[11:10], ci[6], 2'b00, RV_OPC_STORE, 2'b11 };
            default:
                // reserved, passed on unexpanded
                illegal_instruction = 1'b1;
            endcase
        end
        RV_Q1:
        begin
            case (ci[15:13])
            3'b000:
                // c.addi / c.nop
                instruction = { {7{ci[12]}}, ci[6:2], ci[11:7], 3'b000, ci[11:7],
                                RV_OPC_OP_IMM, 2'b11 };
            3'b001, 3'b101:
                // c.jal links to x1, c.j to x0
                instruction = { ci[12], ci[8], ci[10:9], ci[6], ci[7], ci[2], ci[11], ci[5:3],
                                {9{ci[12]}}, 4'b0, ~ci[15], RV_OPC_JAL, 2'b11 };
            3'b010:
                // c.li -> addi rd, x0, imm
                instruction = { {7{ci[12]}}, ci[6:2], 5'b0, 3'b000, ci[11:7],
                                RV_OPC_OP_IMM, 2'b11 };
            3'b011:
            begin
                if (ci[11:7] == 5'h02)
                    // c.addi16sp -> addi x2, x2, nzimm
                    instruction = { {3{ci[12]}}, ci[4:3], ci[5], ci[2], ci[6], 4'b0, 5'h02,
                                    3'b000, 5'h02, RV_OPC_OP_IMM, 2'b11 };
                else
                    // c.lui -> lui rd, nzimm
                    instruction = { {15{ci[12]}}, ci[6:2], ci[11:7], RV_OPC_LUI, 2'b11 };
            end
            3'b100:
            begin
                case (ci[11:10])
                2'b00, 2'b01:
                    // c.srli / c.srai, bit 10 picks arithmetic
                    instruction = { 1'b0, ci[10], 5'b0, ci[6:2], 2'b01, ci[9:7], 3'b101,
                                    2'b01, ci[9:7], RV_OPC_OP_IMM, 2'b11 };
                2'b10:
                    // c.andi
                    instruction = { {7{ci[12]}}, ci[6:2], 2'b01, ci[9:7], 3'b111,
                                    2'b01, ci[9:7], RV_OPC_OP_IMM, 2'b11 };
                default:
                begin
                    case (ci[6:5])
                    2'b00:
                        // c.sub
                        instruction = { 7'b0100000, 2'b01, ci[4:2], 2'b01, ci[9:7], 3'b000,
                                        2'b01, ci[9:7], RV_OPC_OP, 2'b11 };
                    2'b01:
                        // c.xor
                        instruction = { 7'b0, 2'b01, ci[4:2], 2'b01, ci[9:7], 3'b100,
                                        2'b01, ci[9:7], RV_OPC_OP, 2'b11 };
                    2'b10:
                        // c.or
                        instruction = { 7'b0, 2'b01, ci[4:2], 2'b01, ci[9:7], 3'b110,
                                        2'b01, ci[9:7], RV_OPC_OP, 2'b11 };
                    default:
                        // c.and
                        instruction = { 7'b0, 2'b01, ci[4:2], 2'b01, ci[9:7], 3'b111,
                                        2'b01, ci[9:7], RV_OPC_OP, 2'b11 };
                    endcase
                end
                endcase
            end
            default:
                // c.beqz / c.bnez against x0, bit 13 selects bne
                instruction = { {4{ci[12]}}, ci[6:5], ci[2], 5'b0, 2'b01, ci[9:7],
                                2'b00, ci[13], ci[11:10], ci[4:3], ci[12],
                                RV_OPC_BRANCH, 2'b11 };
            endcase
        end
        RV_Q2:
        begin
            case (ci[15:14])
            2'b00:
                // c.slli
                instruction = { 7'b0, ci[6:2], ci[11:7], 3'b001, ci[11:7],
                                RV_OPC_OP_IMM, 2'b11 };
            2'b01:
                // c.lwsp -> lw rd, uimm(x2)
                instruction = { 4'b0, ci[3:2], ci[12], ci[6:4], 2'b00, 5'h02, 3'b010,
                                ci[11:7], RV_OPC_LOAD, 2'b11 };
            2'b10:
            begin
                if (!ci[12])
                begin
                    if (|ci[6:2])
                        // c.mv -> add rd, x0, rs2
                        instruction = { 7'b0, ci[6:2], 5'b0, 3'b000, ci[11:7],
                                        RV_OPC_OP, 2'b11 };
                    else
                        // c.jr -> jalr x0, rs1, 0
                        instruction = { 12'b0, ci[11:7], 3'b000, 5'b0, RV_OPC_JALR, 2'b11 };
                end
                else if (|ci[6:2])
                    // c.add -> add rd, rd, rs2
                    instruction = { 7'b0, ci[6:2], ci[11:7], 3'b000, ci[11:7],
                                    RV_OPC_OP, 2'b11 };
                else if (!(|ci[11:7]))
                    // c.ebreak
                    instruction = { 12'h001, 5'b0, 3'b000, 5'b0, RV_OPC_SYSTEM, 2'b11 };
                else
                    // c.jalr -> jalr x1, rs1, 0
                    instruction = { 12'b0, ci[11:7], 3'b000, 5'h01, RV_OPC_JALR, 2'b11 };
            end
            default:
                // c.swsp -> sw rs2, uimm(x2)
                instruction = { 4'b0, ci[8:7], ci[12], ci[6:2], 5'h02, 3'b010, ci[11:9],
                                2'b00, RV_OPC_STORE, 2'b11 };
            endcase
        end
        default:
            compressed = 1'b0;
        endcase
    end

    assign o_instruction = instruction;
    assign o_compressed = compressed;
    assign o_illegal_instruction = illegal_instruction;

endmodule

`default_nettype wire

// ==== rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// pc of the first halfword after reset
`define RV_RESET_PC     32'h0000_0000

// fetch words held by the aligner, also the memory credits after reset
// must be a power of two and at least 2
`define RV_FETCH_DEPTH  4

// instructions decode can accept after reset
`define RV_DEC_CREDITS  2

`endif

// ==== rv_fetch_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_fetch_align
(
    input   wire            i_clk,
    input   wire            i_reset,
    input   wire            i_mem_valid,
    input   wire[31:0]      i_mem_word,
    output  wire            o_mem_credit,
    rv_inst_if.src          out
);

    localparam int HW_PTR_W = $clog2(2 * `RV_FETCH_DEPTH);
    localparam int WD_PTR_W = HW_PTR_W - 1;
    localparam int CNT_W    = $clog2(2 * `RV_FETCH_DEPTH + 1);

    logic [31:0]            fetch_buf [`RV_FETCH_DEPTH];
    logic [WD_PTR_W-1:0]    wr_ptr;
    logic [HW_PTR_W-1:0]    rd_ptr;
    logic [HW_PTR_W-1:0]    rd_ptr_hi;
    logic [HW_PTR_W-1:0]    rd_ptr_next;
    logic [CNT_W-1:0]       hw_count;
    logic [CNT_W-1:0]       hw_count_next;
    logic [31:0]            pc;
    logic                   mem_credit;
    logic [31:0]            word_lo;
    logic [31:0]            word_hi;
    logic [15:0]            half_lo;
    logic [15:0]            half_hi;
    logic [31:0]            dc_instruction;
    logic                   dc_compressed;
    logic                   dc_illegal;
    logic                   inst_avail;

    // next two halfwords from the read pointer, upper one may wrap the ring
    always_comb
    begin
        rd_ptr_hi = rd_ptr + HW_PTR_W'(1);
        word_lo = fetch_buf[rd_ptr[HW_PTR_W-1:1]];
        word_hi = fetch_buf[rd_ptr_hi[HW_PTR_W-1:1]];
        half_lo = rd_ptr[0] ? word_lo[31:16] : word_lo[15:0];
        half_hi = rd_ptr_hi[0] ? word_hi[31:16] : word_hi[15:0];
    end

    // upper halfword only feeds the expander for a 32-bit encoding
    rv_decode_comp i_rv_decode_comp
    (
        .i_instruction          ({ (half_lo[1:0] == 2'b11) ? half_hi : 16'h0, half_lo }),
        .o_instruction          (dc_instruction),
        .o_compressed           (dc_compressed),
        .o_illegal_instruction  (dc_illegal)
    );

    // a 32-bit instruction needs its second halfword buffered too
    assign inst_avail = (hw_count >= CNT_W'(2)) || ((hw_count != '0) && dc_compressed);
    assign rd_ptr_next = rd_ptr + (dc_compressed ? HW_PTR_W'(1) : HW_PTR_W'(2));

    always_comb
    begin
        hw_count_next = hw_count;
        if (i_mem_valid)
            hw_count_next = hw_count_next + CNT_W'(2);
        if (out.take)
            hw_count_next = hw_count_next - (dc_compressed ? CNT_W'(1) : CNT_W'(2));
    end

    always_ff @(posedge i_clk)
    begin
        if (i_mem_valid)
            fetch_buf[wr_ptr] <= i_mem_word;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            hw_count <= '0;
            pc <= `RV_RESET_PC;
            mem_credit <= 1'b0;
        end
        else
        begin
            if (i_mem_valid)
                wr_ptr <= wr_ptr + WD_PTR_W'(1);
            if (out.take)
            begin
                rd_ptr <= rd_ptr_next;
                pc <= pc + (dc_compressed ? 32'd2 : 32'd4);
            end
            hw_count <= hw_count_next;
            // word index changes once the last halfword of a word is used
            mem_credit <= out.take && (rd_ptr_next[HW_PTR_W-1:1] != rd_ptr[HW_PTR_W-1:1]);
        end
    end

    assign out.valid = inst_avail;
    assign out.inst = '{pc: pc, data: dc_instruction, compressed: dc_compressed,
                        illegal: dc_illegal};
    assign o_mem_credit = mem_credit;

endmodule

`default_nettype wire

// ==== rv_fetch_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_fetch_props
    import rv_pkg::*;
#(
    parameter int CW = 1
)
(
    input   wire            i_clk,
    input   wire            i_reset,
    input   wire[CW-1:0]    i_credit_cnt,
    input   wire            i_valid,
    input   wire            i_ready,
    input   rv_inst_t       i_inst,
    input   wire            i_mem_valid,
    input   wire            i_mem_credit
);

    logic   seen_word;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            seen_word <= 1'b0;
        else if (i_mem_valid)
            seen_word <= 1'b1;
    end

    a_credit_max: assert property (@(posedge i_clk) disable iff (i_reset)
        i_credit_cnt <= CW'(`RV_DEC_CREDITS))
        else $error("decode credit count above its limit");

    // from zero the count can only stay or gain one returned credit
    a_no_underflow: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_credit_cnt == '0) |=> (i_credit_cnt <= CW'(1)))
        else $error("decode credit count wrapped below zero");

    a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_valid && !i_ready) |=> (i_valid && $stable(i_inst)))
        else $error("offered instruction changed while stalled");

    a_credit_after_word: assert property (@(posedge i_clk) disable iff (i_reset)
        i_mem_credit |-> seen_word)
        else $error("memory credit returned before any word arrived");

endmodule

bind rv_fetch_top rv_fetch_props #(.CW($clog2(`RV_DEC_CREDITS + 1))) i_props
(
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_credit_cnt   (i_rv_issue_queue.credit_cnt),
    .i_valid        (i_inst_link.valid),
    .i_ready        (i_inst_link.ready),
    .i_inst         (i_inst_link.inst),
    .i_mem_valid    (i_mem_valid),
    .i_mem_credit   (o_mem_credit)
);

`default_nettype wire

// ==== rv_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_top
    import rv_pkg::*;
(
    input   wire            i_clk,
    input   wire            i_reset,
    input   wire            i_mem_valid,
    input   wire[31:0]      i_mem_word,
    output  wire            o_mem_credit,
    input   wire            i_dec_credit,
    output  wire            o_inst_valid,
    output  wire[31:0]      o_inst_pc,
    output  wire[31:0]      o_inst_data,
    output  wire            o_inst_compressed,
    output  wire            o_inst_illegal
);

    rv_inst_t   inst_out;

    rv_inst_if i_inst_link ();

    rv_fetch_align i_rv_fetch_align
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_mem_valid    (i_mem_valid),
        .i_mem_word     (i_mem_word),
        .o_mem_credit   (o_mem_credit),
        .out            (i_inst_link.src)
    );

    rv_issue_queue i_rv_issue_queue
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .in             (i_inst_link.dst),
        .i_dec_credit   (i_dec_credit),
        .o_inst_valid   (o_inst_valid),
        .o_inst         (inst_out)
    );

    assign o_inst_pc = inst_out.pc;
    assign o_inst_data = inst_out.data;
    assign o_inst_compressed = inst_out.compressed;
    assign o_inst_illegal = inst_out.illegal;

endmodule

`default_nettype wire

// ==== rv_inst_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rv_inst_if
    import rv_pkg::*;
();

    logic       valid;
    rv_inst_t   inst;
    logic       ready;
    // valid && ready, raised by the queue in the transfer cycle
    logic       take;

    modport src
    (
        output valid,
        output inst,
        input  ready,
        input  take
    );

    modport dst
    (
        input  valid,
        input  inst,
        output ready,
        output take
    );

endinterface

`default_nettype wire

// ==== rv_issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_issue_queue
    import rv_pkg::*;
(
    input   wire            i_clk,
    input   wire            i_reset,
    rv_inst_if.dst          in,
    input   wire            i_dec_credit,
    output  wire            o_inst_valid,
    output  rv_inst_t       o_inst
);

    localparam int CRED_W = $clog2(`RV_DEC_CREDITS + 1);

    logic [CRED_W-1:0]  credit_cnt;
    logic               full;
    rv_inst_t           inst_q;
    logic               send;
    logic               ready;
    logic               take;

    // one instruction leaves per held credit
    assign send = full && (credit_cnt != '0);

    // the slot frees up in the same cycle it is sent
    assign ready = !full || send;
    assign take = in.valid && ready;

    always_ff @(posedge i_clk)
    begin
        if (take)
            inst_q <= in.inst;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            full <= 1'b0;
            credit_cnt <= CRED_W'(`RV_DEC_CREDITS);
        end
        else
        begin
            if (take)
                full <= 1'b1;
            else if (send)
                full <= 1'b0;

            case ({ i_dec_credit, send })
            2'b10:
                credit_cnt <= credit_cnt + CRED_W'(1);
            2'b01:
                credit_cnt <= credit_cnt - CRED_W'(1);
            default:
                credit_cnt <= credit_cnt;
            endcase
        end
    end

    assign in.ready = ready;
    assign in.take = take;
    assign o_inst_valid = send;
    assign o_inst = inst_q;

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // major opcodes, instruction bits 6:2
    typedef enum logic [4:0]
    {
        RV_OPC_LOAD   = 5'b00000,
        RV_OPC_OP_IMM = 5'b00100,
        RV_OPC_STORE  = 5'b01000,
        RV_OPC_OP     = 5'b01100,
        RV_OPC_LUI    = 5'b01101,
        RV_OPC_BRANCH = 5'b11000,
        RV_OPC_JALR   = 5'b11001,
        RV_OPC_JAL    = 5'b11011,
        RV_OPC_SYSTEM = 5'b11100
    } rv_opcode_e;

    // instruction bits 1:0
    typedef enum logic [1:0]
    {
        RV_Q0       = 2'b00,
        RV_Q1       = 2'b01,
        RV_Q2       = 2'b10,
        RV_Q_32BIT  = 2'b11
    } rv_quadrant_e;

    // one rebuilt instruction
    typedef struct packed
    {
        logic [31:0]    pc;
        logic [31:0]    data;
        logic           compressed;
        logic           illegal;
    } rv_inst_t;

endpackage

`default_nettype wire

// ==== sources.f ====
+incdir+.
rv_pkg.sv
rv_inst_if.sv
rv_decode_comp.sv
rv_fetch_align.sv
rv_issue_queue.sv
rv_fetch_top.sv
rv_fetch_props.sv
tb_rv_fetch.sv

// ==== tb_rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module tb_rv_fetch;

    localparam int MAX_ENTRIES = 40;
    localparam int TIMEOUT     = 5000;

    logic           i_clk;
    logic           i_reset;
    logic           i_mem_valid;
    logic [31:0]    i_mem_word;
    logic           o_mem_credit;
    logic           i_dec_credit;
    logic           o_inst_valid;
    logic [31:0]    o_inst_pc;
    logic [31:0]    o_inst_data;
    logic           o_inst_compressed;
    logic           o_inst_illegal;

    // program table: halfword count, fragment, expected expansion and flags
    int             tab_hw [MAX_ENTRIES];
    logic [31:0]    tab_frag [MAX_ENTRIES];
    logic [31:0]    tab_data [MAX_ENTRIES];
    logic           tab_comp [MAX_ENTRIES];
    logic           tab_ill [MAX_ENTRIES];
    int             n_entries;
    logic [15:0]    hw_stream [2 * MAX_ENTRIES];
    logic [31:0]    words [MAX_ENTRIES];
    int             n_words;

    logic [31:0]    lfsr;
    int             mem_credits;
    int             word_idx;
    int             words_sent;
    int             credits_seen;
    int             owed;
    int             delay;
    logic           withhold;
    int             rx_count;
    logic [31:0]    exp_pc;
    int             check_errors;
    int             timeouts;

    rv_fetch_top i_rv_fetch_top
    (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_mem_valid        (i_mem_valid),
        .i_mem_word         (i_mem_word),
        .o_mem_credit       (o_mem_credit),
        .i_dec_credit       (i_dec_credit),
        .o_inst_valid       (o_inst_valid),
        .o_inst_pc          (o_inst_pc),
        .o_inst_data        (o_inst_data),
        .o_inst_compressed  (o_inst_compressed),
        .o_inst_illegal     (o_inst_illegal)
    );

    always #50 i_clk = ~i_clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return { s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0] };
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    task automatic add_entry(input int hw, input logic [31:0] frag, input logic [31:0] data,
                             input logic comp, input logic ill);
        tab_hw[n_entries] = hw;
        tab_frag[n_entries] = frag;
        tab_data[n_entries] = data;
        tab_comp[n_entries] = comp;
        tab_ill[n_entries] = ill;
        n_entries = n_entries + 1;
    endtask

    task automatic build_program();
        int pos;
        pos = 0;
        n_entries = 0;
        add_entry(2, 32'h002081b3, 32'h002081b3, 1'b0, 1'b0);  // add, aligned
        add_entry(1, 32'h0040, 32'h00410413, 1'b1, 1'b0);      // c.addi4spn
        add_entry(2, 32'h123453b7, 32'h123453b7, 1'b0, 1'b0);  // lui, straddles two words
        add_entry(1, 32'h4144, 32'h00452483, 1'b1, 1'b0);      // c.lw
        add_entry(1, 32'h8000, 32'h00000000, 1'b1, 1'b1);      // reserved Q0
        add_entry(1, 32'hc504, 32'h00952423, 1'b1, 1'b0);      // c.sw
        add_entry(2, 32'h00100093, 32'h00100093, 1'b0, 1'b0);
        add_entry(1, 32'h0001, 32'h00000013, 1'b1, 1'b0);      // c.nop
        add_entry(1, 32'h157d, 32'hfff50513, 1'b1, 1'b0);      // c.addi
        add_entry(1, 32'h2021, 32'h008000ef, 1'b1, 1'b0);      // c.jal
        add_entry(1, 32'hbffd, 32'hfffff06f, 1'b1, 1'b0);      // c.j
        add_entry(1, 32'h428d, 32'h00300293, 1'b1, 1'b0);      // c.li
        add_entry(1, 32'h717d, 32'hff010113, 1'b1, 1'b0);      // c.addi16sp
        add_entry(1, 32'h6285, 32'h000012b7, 1'b1, 1'b0);      // c.lui
        add_entry(1, 32'h8005, 32'h00145413, 1'b1, 1'b0);      // c.srli
        add_entry(1, 32'h8489, 32'h4024d493, 1'b1, 1'b0);      // c.srai
        add_entry(1, 32'h997d, 32'hfff57513, 1'b1, 1'b0);      // c.andi
        add_entry(1, 32'h8c05, 32'h40940433, 1'b1, 1'b0);      // c.sub
        add_entry(1, 32'h8c25, 32'h00944433, 1'b1, 1'b0);
        add_entry(1, 32'h8c45, 32'h00946433, 1'b1, 1'b0);
        add_entry(1, 32'h8c65, 32'h00947433, 1'b1, 1'b0);
        add_entry(1, 32'hc011, 32'h00040263, 1'b1, 1'b0);      // c.beqz
        add_entry(1, 32'hfcfd, 32'hfe049fe3, 1'b1, 1'b0);      // c.bnez
        add_entry(1, 32'h028e, 32'h00329293, 1'b1, 1'b0);      // c.slli
        add_entry(1, 32'h4322, 32'h00812303, 1'b1, 1'b0);      // c.lwsp
        add_entry(1, 32'h8082, 32'h00008067, 1'b1, 1'b0);      // c.jr
        add_entry(1, 32'h852e, 32'h00b00533, 1'b1, 1'b0);      // c.mv
        add_entry(1, 32'h9002, 32'h00100073, 1'b1, 1'b0);      // c.ebreak
        add_entry(1, 32'h9282, 32'h000280e7, 1'b1, 1'b0);      // c.jalr
        add_entry(1, 32'h952e, 32'h00b50533, 1'b1, 1'b0);      // c.add
        add_entry(1, 32'hc626, 32'h00912623, 1'b1, 1'b0);      // c.swsp
        for (int i = 0; i < n_entries; i++)
        begin
            hw_stream[pos] = tab_frag[i][15:0];
            if (tab_hw[i] == 2)
                hw_stream[pos + 1] = tab_frag[i][31:16];
            pos = pos + tab_hw[i];
        end
        n_words = pos / 2;
        for (int i = 0; i < n_words; i++)
            words[i] = { hw_stream[2 * i + 1], hw_stream[2 * i] };
    endtask

    // memory and decode models share one LFSR
    always @(posedge i_clk)
    begin
        if (i_reset)
        begin
            mem_credits = `RV_FETCH_DEPTH;
            i_mem_valid <= 1'b0;
            i_dec_credit <= 1'b0;
        end
        else
        begin
            i_mem_valid <= 1'b0;
            i_dec_credit <= 1'b0;
            if (o_mem_credit)
            begin
                mem_credits = mem_credits + 1;
                credits_seen = credits_seen + 1;
                assert (credits_seen <= words_sent)
                else
                begin
                    check_errors = check_errors + 1;
                    $display("memory credit returned for a word that was never sent");
                end
            end
            if (mem_credits > 0 && word_idx < n_words && take_bit())
            begin
                i_mem_valid <= 1'b1;
                i_mem_word <= words[word_idx];
                word_idx = word_idx + 1;
                mem_credits = mem_credits - 1;
                words_sent = words_sent + 1;
            end
            if (o_inst_valid)
                owed = owed + 1;
            if (!withhold && owed > 0)
            begin
                if (delay == 0)
                begin
                    i_dec_credit <= 1'b1;
                    owed = owed - 1;
                    delay = { take_bit(), take_bit() };
                end
                else
                    delay = delay - 1;
            end
        end
    end

    always @(posedge i_clk)
    begin
        if (!i_reset && o_inst_valid)
        begin
            assert (rx_count < n_entries)
            else
            begin
                check_errors = check_errors + 1;
                $display("instruction seen after the end of the program");
            end
            if (rx_count < n_entries)
            begin
                assert (o_inst_pc == exp_pc)
                else
                begin
                    check_errors = check_errors + 1;
                    $display("[ERROR] o_inst_pc got %h expected %h", o_inst_pc, exp_pc);
                end
                // raw encoding of an illegal instruction is not checked
                assert (tab_ill[rx_count] || o_inst_data == tab_data[rx_count])
                else
                begin
                    check_errors = check_errors + 1;
                    $display("[ERROR] o_inst_data got %h expected %h", o_inst_data,
                             tab_data[rx_count]);
                end
                assert (o_inst_compressed == tab_comp[rx_count])
                else
                begin
                    check_errors = check_errors + 1;
                    $display("[ERROR] o_inst_compressed got %h expected %h",
                             o_inst_compressed, tab_comp[rx_count]);
                end
                assert (o_inst_illegal == tab_ill[rx_count])
                else
                begin
                    check_errors = check_errors + 1;
                    $display("[ERROR] o_inst_illegal got %h expected %h", o_inst_illegal,
                             tab_ill[rx_count]);
                end
                exp_pc = exp_pc + 32'(2 * tab_hw[rx_count]);
                rx_count = rx_count + 1;
            end
        end
    end

    initial
    begin
        int cycles;
        i_clk = 1'b0;
        i_reset = 1'b1;
        i_mem_valid = 1'b0;
        i_mem_word = '0;
        i_dec_credit = 1'b0;
        lfsr = 32'hf0c0;
        word_idx = 0;
        words_sent = 0;
        credits_seen = 0;
        owed = 0;
        delay = 0;
        withhold = 1'b1;
        rx_count = 0;
        exp_pc = `RV_RESET_PC;
        check_errors = 0;
        timeouts = 0;
        build_program();
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;

        // decode returns nothing until the first credits are used up
        cycles = 0;
        while (rx_count < `RV_DEC_CREDITS && cycles < TIMEOUT)
        begin
            @(posedge i_clk);
            cycles = cycles + 1;
        end
        if (cycles >= TIMEOUT)
        begin
            timeouts = timeouts + 1;
            $display("timed out waiting for the first instructions");
        end
        repeat (40) @(posedge i_clk);
        assert (rx_count == `RV_DEC_CREDITS)
        else
        begin
            check_errors = check_errors + 1;
            $display("[ERROR] rx_count got %h expected %h", rx_count, `RV_DEC_CREDITS);
        end
        withhold <= 1'b0;

        cycles = 0;
        while (rx_count < n_entries && cycles < TIMEOUT)
        begin
            @(posedge i_clk);
            cycles = cycles + 1;
        end
        if (cycles >= TIMEOUT)
        begin
            timeouts = timeouts + 1;
            $display("timed out waiting for the rest of the program");
        end
        repeat (20) @(posedge i_clk);

        // every word is released once the whole program has left
        assert (credits_seen == n_words)
        else
        begin
            check_errors = check_errors + 1;
            $display("[ERROR] o_mem_credit pulses got %h expected %h", credits_seen, n_words);
        end

        $display("errors: %0d check, %0d timeout", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
